// ==== design/frame_arbiter.sv ====
// ==========================================================
// Frame arbiter
// Config register sequence, player start, serializer mux
// ==========================================================
`timescale 1ns/10ps

module frame_arbiter (
   input  logic                      clk,
   input  logic                      i_rst_n,
   input  logic                      i_static_dyn,
   input  logic                      i_new_display,
   input  logic                      i_new_config_val,
   input  max7219_pkg::display_cfg_t i_display_cfg,
   input  max7219_pkg::frame_req_t   i_static_req,
   input  max7219_pkg::frame_req_t   i_scroll_req,
   input  logic                      i_static_busy,
   input  logic                      i_scroll_busy,
   input  logic                      i_ser_ready,
   input  logic                      i_frame_done,
   output logic                      o_start_static,
   output logic                      o_start_scroll,
   output logic                      o_static_ready,
   output logic                      o_scroll_ready,
   output max7219_pkg::frame_req_t   o_ser_req,
   output logic                      o_config_done
);
   import max7219_pkg::*;

   display_cfg_t cfg_q;
   frame_t       cfg_frame;
   logic [2:0]   cfg_idx;
   logic [2:0]   done_cnt;
   logic         cfg_run;
   logic         cfg_sel;
   logic         inflight_cfg;
   logic         mode_q;
   logic         start_ok;

   // Config frames win whenever some are left to send
   assign cfg_sel  = cfg_run && (cfg_idx < 3'd5);
   assign start_ok = !i_static_busy && !i_scroll_busy && !o_start_static && !o_start_scroll;

   always_comb begin
      case (cfg_idx)
         3'd0: begin
            cfg_frame.addr = REG_DISPLAY_TEST;
            cfg_frame.data = {7'd0, cfg_q.display_test};
         end
         3'd1: begin
            cfg_frame.addr = REG_DECODE_MODE;
            cfg_frame.data = cfg_q.decode_mode;
         end
         3'd2: begin
            cfg_frame.addr = REG_INTENSITY;
            cfg_frame.data = cfg_q.intensity;
         end
         3'd3: begin
            cfg_frame.addr = REG_SCAN_LIMIT;
            cfg_frame.data = cfg_q.scan_limit;
         end
         default: begin
            cfg_frame.addr = REG_SHUTDOWN;
            cfg_frame.data = cfg_q.shutdown;
         end
      endcase
   end

   // ==========================================================
   // Serializer request mux and ready return
   // ==========================================================
   always_comb begin
      if (cfg_sel) begin
         o_ser_req.valid = 1'b1;
         o_ser_req.frame = cfg_frame;
      end else if (mode_q) begin
         o_ser_req = i_scroll_req;
      end else begin
         o_ser_req = i_static_req;
      end
   end

   assign o_static_ready = i_ser_ready && !cfg_sel && !mode_q;
   assign o_scroll_ready = i_ser_ready && !cfg_sel && mode_q;

   always_ff @(posedge clk) begin
      if (i_new_config_val) begin
         cfg_q <= i_display_cfg;
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_start_static <= 1'b0;
         o_start_scroll <= 1'b0;
         o_config_done  <= 1'b0;
         mode_q         <= 1'b0;
         cfg_run        <= 1'b0;
         cfg_idx        <= '0;
         done_cnt       <= '0;
         inflight_cfg   <= 1'b0;
      end else begin
         o_start_static <= 1'b0;
         o_start_scroll <= 1'b0;
         o_config_done  <= 1'b0;
         if (i_new_display && start_ok) begin
            mode_q         <= i_static_dyn;
            o_start_static <= !i_static_dyn;
            o_start_scroll <= i_static_dyn;
         end
         if (i_new_config_val) begin
            cfg_run  <= 1'b1;
            cfg_idx  <= '0;
            done_cnt <= '0;
         end else begin
            if (cfg_sel && i_ser_ready) begin
               cfg_idx <= cfg_idx + 3'd1;
            end
            // Done once the fifth register frame has left the pins
            if (i_frame_done && inflight_cfg) begin
               done_cnt <= done_cnt + 3'd1;
               if (done_cnt == 3'd4) begin
                  cfg_run       <= 1'b0;
                  o_config_done <= 1'b1;
               end
            end
         end
         if (o_ser_req.valid && i_ser_ready) begin
            inflight_cfg <= cfg_sel;
         end
      end
   end

endmodule

// ==== design/max7219_display_ctrl.sv ====
// ==========================================================
// MAX7219 display controller top level
// Static player and scroller behind the frame arbiter
// ==========================================================
`timescale 1ns/10ps

module max7219_display_ctrl (
   input  logic                      clk,
   input  logic                      i_rst_n,
   input  logic                      i_static_dyn,
   input  logic                      i_new_display,
   input  logic                      i_new_config_val,
   input  max7219_pkg::display_cfg_t i_display_cfg,
   input  max7219_pkg::static_cfg_t  i_static_cfg,
   input  max7219_pkg::scroll_cfg_t  i_scroll_cfg,
   input  max7219_pkg::static_wr_t   i_static_wr,
   input  max7219_pkg::scroll_wr_t   i_scroll_wr,
   output logic                      o_config_done,
   output logic                      o_static_busy,
   output logic                      o_scroller_busy,
   output logic                      o_max7219_clk,
   output logic                      o_max7219_data,
   output logic                      o_max7219_load
);
   import max7219_pkg::*;

   frame_req_t static_req;
   frame_req_t scroll_req;
   frame_req_t ser_req;
   logic       static_ready;
   logic       scroll_ready;
   logic       start_static;
   logic       start_scroll;
   logic       ser_ready;
   logic       frame_done;

   static_player u_static_player (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_start (start_static),
      .i_cfg   (i_static_cfg),
      .i_wr    (i_static_wr),
      .i_ready (static_ready),
      .o_req   (static_req),
      .o_busy  (o_static_busy)
   );

   scroller u_scroller (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_start (start_scroll),
      .i_cfg   (i_scroll_cfg),
      .i_wr    (i_scroll_wr),
      .i_ready (scroll_ready),
      .o_req   (scroll_req),
      .o_busy  (o_scroller_busy)
   );

   frame_arbiter u_frame_arbiter (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .i_static_dyn     (i_static_dyn),
      .i_new_display    (i_new_display),
      .i_new_config_val (i_new_config_val),
      .i_display_cfg    (i_display_cfg),
      .i_static_req     (static_req),
      .i_scroll_req     (scroll_req),
      .i_static_busy    (o_static_busy),
      .i_scroll_busy    (o_scroller_busy),
      .i_ser_ready      (ser_ready),
      .i_frame_done     (frame_done),
      .o_start_static   (start_static),
      .o_start_scroll   (start_scroll),
      .o_static_ready   (static_ready),
      .o_scroll_ready   (scroll_ready),
      .o_ser_req        (ser_req),
      .o_config_done    (o_config_done)
   );

   max7219_serializer u_serializer (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_req          (ser_req),
      .o_ready        (ser_ready),
      .o_frame_done   (frame_done),
      .o_max7219_clk  (o_max7219_clk),
      .o_max7219_data (o_max7219_data),
      .o_max7219_load (o_max7219_load)
   );

endmodule

// ==== design/max7219_pkg.sv ====
// ==========================================================
// MAX7219 controller shared definitions
// Register map, serial timing constants and bus structs
// ==========================================================

package max7219_pkg;

   // Serial link timing, in clk cycles
   localparam logic [7:0] MAX_HALF_PERIOD = 8'd4;
   localparam logic [7:0] LOAD_DURATION   = 8'd4;

   localparam int RAM_ADDR_W = 8;

   // MAX7219 register addresses
   localparam logic [7:0] REG_DIGIT0       = 8'd1;
   localparam logic [7:0] REG_DECODE_MODE  = 8'd9;
   localparam logic [7:0] REG_INTENSITY    = 8'd10;
   localparam logic [7:0] REG_SCAN_LIMIT   = 8'd11;
   localparam logic [7:0] REG_SHUTDOWN     = 8'd12;
   localparam logic [7:0] REG_DISPLAY_TEST = 8'd15;

   localparam logic [7:0] NB_DIGITS = 8'd8;

   // ==========================================================
   // Frames and frame requests
   // ==========================================================
   typedef struct packed {
      logic [7:0] addr;
      logic [7:0] data;
   } frame_t;

   typedef struct packed {
      logic   valid;
      frame_t frame;
   } frame_req_t;

   // ==========================================================
   // Host configuration and RAM write ports
   // ==========================================================
   typedef struct packed {
      logic       display_test;
      logic [7:0] decode_mode;
      logic [7:0] intensity;
      logic [7:0] scan_limit;
      logic [7:0] shutdown;
   } display_cfg_t;

   typedef struct packed {
      logic [RAM_ADDR_W-1:0] start_ptr;
      logic [RAM_ADDR_W-1:0] last_ptr;
      logic                  loop;
   } static_cfg_t;

   typedef struct packed {
      logic [RAM_ADDR_W-1:0] ram_start_ptr;
      logic [7:0]            msg_length;
      logic [31:0]           tempo_cnt;
   } scroll_cfg_t;

   typedef struct packed {
      logic                  we;
      logic [RAM_ADDR_W-1:0] addr;
      frame_t                data;
   } static_wr_t;

   typedef struct packed {
      logic                  we;
      logic [RAM_ADDR_W-1:0] addr;
      logic [7:0]            data;
   } scroll_wr_t;

endpackage

// ==== design/max7219_serializer.sv ====
// ==========================================================
// MAX7219 serial link
// 16-bit MSB-first shifter with clock and load timing
// ==========================================================
`timescale 1ns/10ps

module max7219_serializer (
   input  logic                    clk,
   input  logic                    i_rst_n,
   input  max7219_pkg::frame_req_t i_req,
   output logic                    o_ready,
   output logic                    o_frame_done,
   output logic                    o_max7219_clk,
   output logic                    o_max7219_data,
   output logic                    o_max7219_load
);
   import max7219_pkg::*;

   logic [15:0] shift_reg;
   logic [7:0]  half_cnt;
   logic [7:0]  load_cnt;
   logic [3:0]  bit_cnt;
   logic        shifting;
   logic        loading;

   assign o_ready        = !shifting && !loading;
   assign o_max7219_data = shift_reg[15];

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         shift_reg      <= '0;
         half_cnt       <= '0;
         load_cnt       <= '0;
         bit_cnt        <= '0;
         shifting       <= 1'b0;
         loading        <= 1'b0;
         o_frame_done   <= 1'b0;
         o_max7219_clk  <= 1'b0;
         o_max7219_load <= 1'b0;
      end else begin
         o_frame_done <= 1'b0;
         if (i_req.valid && o_ready) begin
            shift_reg <= i_req.frame;
            shifting  <= 1'b1;
            half_cnt  <= '0;
            bit_cnt   <= '0;
         end else if (shifting) begin
            if (half_cnt == MAX_HALF_PERIOD - 8'd1) begin
               half_cnt      <= '0;
               o_max7219_clk <= !o_max7219_clk;
               // Falling serial clock closes the current bit
               if (o_max7219_clk) begin
                  if (bit_cnt == 4'd15) begin
                     shifting       <= 1'b0;
                     loading        <= 1'b1;
                     o_max7219_load <= 1'b1;
                     load_cnt       <= '0;
                  end else begin
                     bit_cnt   <= bit_cnt + 4'd1;
                     shift_reg <= {shift_reg[14:0], 1'b0};
                  end
               end
            end else begin
               half_cnt <= half_cnt + 8'd1;
            end
         end else if (loading) begin
            if (load_cnt == LOAD_DURATION - 8'd1) begin
               loading        <= 1'b0;
               o_max7219_load <= 1'b0;
               o_frame_done   <= 1'b1;
            end else begin
               load_cnt <= load_cnt + 8'd1;
            end
         end
      end
   end

endmodule

// ==== design/scroller.sv ====
// ==========================================================
// Message scroller
// Column RAM, window offset, digit counter and tempo timer
// ==========================================================
`timescale 1ns/10ps

module scroller (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  logic                     i_start,
   input  max7219_pkg::scroll_cfg_t i_cfg,
   input  max7219_pkg::scroll_wr_t  i_wr,
   input  logic                     i_ready,
   output max7219_pkg::frame_req_t  o_req,
   output logic                     o_busy
);
   import max7219_pkg::*;

   logic [7:0]            col_ram [0:(1<<RAM_ADDR_W)-1];
   logic [RAM_ADDR_W-1:0] ram_start_q;
   logic [RAM_ADDR_W-1:0] rd_addr;
   logic [7:0]            len_q;
   logic [31:0]           tempo_q;
   logic [31:0]           wait_cnt;
   logic [7:0]            offset;
   logic [7:0]            idx;
   logic [7:0]            idx_next;
   logic [7:0]            digit;
   logic                  fetch;
   logic                  waiting;
   logic                  req_valid;
   frame_t                req_frame;

   assign o_req.valid = req_valid;
   assign o_req.frame = req_frame;

   // Message index wraps on the length, RAM address on 256
   assign idx_next = (idx == len_q - 8'd1) ? 8'd0 : idx + 8'd1;
   assign rd_addr  = ram_start_q + idx;

   always_ff @(posedge clk) begin
      if (i_wr.we) begin
         col_ram[i_wr.addr] <= i_wr.data;
      end
   end

   always_ff @(posedge clk) begin
      if (i_start) begin
         ram_start_q <= i_cfg.ram_start_ptr;
         len_q       <= i_cfg.msg_length;
         tempo_q     <= i_cfg.tempo_cnt;
      end
      if (fetch) begin
         req_frame.addr <= REG_DIGIT0 + digit;
         req_frame.data <= col_ram[rd_addr];
      end
   end

   // ==========================================================
   // Window stepping
   // ==========================================================
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_busy    <= 1'b0;
         fetch     <= 1'b0;
         waiting   <= 1'b0;
         req_valid <= 1'b0;
         offset    <= '0;
         idx       <= '0;
         digit     <= '0;
         wait_cnt  <= '0;
      end else begin
         if (i_start) begin
            o_busy <= 1'b1;
            fetch  <= 1'b1;
            offset <= '0;
            idx    <= '0;
            digit  <= '0;
         end else if (fetch) begin
            fetch     <= 1'b0;
            req_valid <= 1'b1;
         end else if (req_valid && i_ready) begin
            req_valid <= 1'b0;
            if (digit == NB_DIGITS - 8'd1) begin
               digit <= '0;
               // No pause after the last window
               if (offset == len_q - 8'd1) begin
                  o_busy <= 1'b0;
               end else begin
                  waiting  <= 1'b1;
                  wait_cnt <= 32'd1;
               end
            end else begin
               digit <= digit + 8'd1;
               idx   <= idx_next;
               fetch <= 1'b1;
            end
         end else if (waiting) begin
            if (wait_cnt >= tempo_q) begin
               waiting <= 1'b0;
               offset  <= offset + 8'd1;
               idx     <= offset + 8'd1;
               fetch   <= 1'b1;
            end else begin
               wait_cnt <= wait_cnt + 32'd1;
            end
         end
      end
   end

endmodule

// ==== design/static_player.sv ====
// ==========================================================
// Static player
// Command word RAM and pointer sequencer with loop support
// ==========================================================
`timescale 1ns/10ps

module static_player (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  logic                     i_start,
   input  max7219_pkg::static_cfg_t i_cfg,
   input  max7219_pkg::static_wr_t  i_wr,
   input  logic                     i_ready,
   output max7219_pkg::frame_req_t  o_req,
   output logic                     o_busy
);
   import max7219_pkg::*;

   frame_t                word_ram [0:(1<<RAM_ADDR_W)-1];
   logic [RAM_ADDR_W-1:0] ptr;
   logic [RAM_ADDR_W-1:0] start_q;
   logic [RAM_ADDR_W-1:0] last_q;
   logic                  fetch;
   logic                  req_valid;
   frame_t                req_frame;

   assign o_req.valid = req_valid;
   assign o_req.frame = req_frame;

   // Host write port
   always_ff @(posedge clk) begin
      if (i_wr.we) begin
         word_ram[i_wr.addr] <= i_wr.data;
      end
   end

   // Pointer bounds are held for the whole run
   always_ff @(posedge clk) begin
      if (i_start) begin
         start_q <= i_cfg.start_ptr;
         last_q  <= i_cfg.last_ptr;
      end
      if (fetch) begin
         req_frame <= word_ram[ptr];
      end
   end

   // ==========================================================
   // Sequencer
   // ==========================================================
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_busy    <= 1'b0;
         fetch     <= 1'b0;
         req_valid <= 1'b0;
         ptr       <= '0;
      end else begin
         if (i_start) begin
            o_busy <= 1'b1;
            fetch  <= 1'b1;
            ptr    <= i_cfg.start_ptr;
         end else if (fetch) begin
            fetch     <= 1'b0;
            req_valid <= 1'b1;
         end else if (req_valid && i_ready) begin
            req_valid <= 1'b0;
            if (ptr == last_q) begin
               // End of pass, loop bit taken live
               if (i_cfg.loop) begin
                  ptr   <= start_q;
                  fetch <= 1'b1;
               end else begin
                  o_busy <= 1'b0;
               end
            end else begin
               ptr   <= ptr + 1'b1;
               fetch <= 1'b1;
            end
         end
      end
   end

endmodule

// ==== filelist.f ====
design/max7219_pkg.sv
design/static_player.sv
design/scroller.sv
design/frame_arbiter.sv
design/max7219_serializer.sv
design/max7219_display_ctrl.sv
verification/max7219_chk.sv
verification/tb_max7219.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MAX7219 controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_max7219 \
   -f filelist.f -o tb_max7219_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_max7219_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Verification failed" "$LOG"; then
   exit 1
fi
exit 0

// ==== verification/max7219_chk.sv ====
// ==========================================================
// Serial pin assertions for the MAX7219 serializer
// Bound into every serializer instance
// ==========================================================
`timescale 1ns/10ps

module max7219_chk (
   input logic clk,
   input logic i_rst_n,
   input logic i_ready,
   input logic i_ser_clk,
   input logic i_ser_data,
   input logic i_ser_load
);

   // Serial clock stays parked low during the load pulse
   a_clk_low_in_load : assert property (
      @(posedge clk) disable iff (!i_rst_n) i_ser_load |-> !i_ser_clk
   ) else $error("serial clock high while load is high");

   // Data only moves while the serial clock is low
   a_data_stable : assert property (
      @(posedge clk) disable iff (!i_rst_n) i_ser_clk |-> $stable(i_ser_data)
   ) else $error("serial data changed while serial clock is high");

   a_busy_in_load : assert property (
      @(posedge clk) disable iff (!i_rst_n) i_ser_load |-> !i_ready
   ) else $error("serializer ready while load is high");

endmodule

bind max7219_serializer max7219_chk u_chk (
   .clk        (clk),
   .i_rst_n    (i_rst_n),
   .i_ready    (o_ready),
   .i_ser_clk  (o_max7219_clk),
   .i_ser_data (o_max7219_data),
   .i_ser_load (o_max7219_load)
);

// ==== verification/tb_max7219.sv ====
// ==========================================================
// Testbench for the MAX7219 display controller
// Directed tests, serial frame decoder, timeout and report
// ==========================================================
`timescale 1ns/10ps

module tb_max7219;
   import max7219_pkg::*;

   localparam int FRAME_CYCLES   = 32 * int'(MAX_HALF_PERIOD) + int'(LOAD_DURATION);
   localparam int DRAIN_CYCLES   = FRAME_CYCLES + 16;
   localparam int MSG_LEN        = 5;
   localparam int TEMPO          = 20;
   // Frames over all tests, with slack for the loop test
   localparam int TOTAL_FRAMES   = 130;
   localparam int TIMEOUT_CYCLES = 2 * (TOTAL_FRAMES * FRAME_CYCLES
                                   + 2 * MSG_LEN * TEMPO + 10 * DRAIN_CYCLES);

   logic         clk = 1'b0;
   logic         i_rst_n;
   logic         i_static_dyn;
   logic         i_new_display;
   logic         i_new_config_val;
   display_cfg_t i_display_cfg;
   static_cfg_t  i_static_cfg;
   scroll_cfg_t  i_scroll_cfg;
   static_wr_t   i_static_wr;
   scroll_wr_t   i_scroll_wr;
   logic         o_config_done;
   logic         o_static_busy;
   logic         o_scroller_busy;
   logic         o_max7219_clk;
   logic         o_max7219_data;
   logic         o_max7219_load;

   // Reference copies of the host RAM writes
   logic [15:0]  static_mem [0:255];
   logic [7:0]   scroll_mem [0:255];
   logic [15:0]  frames [$];
   logic [15:0]  cfg_seen [$];
   logic [15:0]  scroll_seen [$];
   logic [15:0]  shift_in = '0;
   logic         ser_clk_q = 1'b0;
   logic         load_q = 1'b0;
   logic [31:0]  rng_state = 32'h50ed_43ec;
   int           done_cnt = 0;
   int           err_cnt = 0;
   int           test_cnt = 0;
   int           cycle_cnt = 0;

   always #2 clk = ~clk;

   max7219_display_ctrl uut (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .i_static_dyn     (i_static_dyn),
      .i_new_display    (i_new_display),
      .i_new_config_val (i_new_config_val),
      .i_display_cfg    (i_display_cfg),
      .i_static_cfg     (i_static_cfg),
      .i_scroll_cfg     (i_scroll_cfg),
      .i_static_wr      (i_static_wr),
      .i_scroll_wr      (i_scroll_wr),
      .o_config_done    (o_config_done),
      .o_static_busy    (o_static_busy),
      .o_scroller_busy  (o_scroller_busy),
      .o_max7219_clk    (o_max7219_clk),
      .o_max7219_data   (o_max7219_data),
      .o_max7219_load   (o_max7219_load)
   );

   // ==========================================================
   // Serial frame decoder sampled on the falling clk edge
   // ==========================================================
   always @(negedge clk) begin
      if (o_max7219_clk && !ser_clk_q) begin
         shift_in = {shift_in[14:0], o_max7219_data};
      end
      if (o_max7219_load && !load_q) begin
         frames.push_back(shift_in);
      end
      if (o_config_done) begin
         done_cnt++;
      end
      ser_clk_q = o_max7219_clk;
      load_q    = o_max7219_load;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Verification failed");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] random_word();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Register order of a configuration sequence
   function automatic logic [15:0] config_frame(input display_cfg_t cfg, input int n);
      case (n)
         0: return {REG_DISPLAY_TEST, 7'd0, cfg.display_test};
         1: return {REG_DECODE_MODE, cfg.decode_mode};
         2: return {REG_INTENSITY, cfg.intensity};
         3: return {REG_SCAN_LIMIT, cfg.scan_limit};
         default: return {REG_SHUTDOWN, cfg.shutdown};
      endcase
   endfunction

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      assert (got == exp) else begin
         $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      test_cnt++;
      $display("%0t ns  test %s finished with %0d error(s)", $time, name,
               err_cnt - errs_before);
   endtask

   task automatic write_static_ram(input logic [7:0] start, input int len);
      logic [7:0]  addr;
      logic [15:0] word;
      int          i;
      for (i = 0; i < len; i++) begin
         addr = start + 8'(i);
         word = 16'(random_word());
         static_mem[addr] = word;
         @(posedge clk);
         i_static_wr <= {1'b1, addr, word};
      end
      @(posedge clk);
      i_static_wr <= '0;
   endtask

   task automatic write_scroll_ram(input logic [7:0] start, input int len);
      logic [7:0] addr;
      logic [7:0] col;
      int         i;
      for (i = 0; i < len; i++) begin
         addr = start + 8'(i);
         col  = 8'(random_word());
         scroll_mem[addr] = col;
         @(posedge clk);
         i_scroll_wr <= {1'b1, addr, col};
      end
      @(posedge clk);
      i_scroll_wr <= '0;
   endtask

   task automatic send_config(input display_cfg_t cfg);
      @(posedge clk);
      i_display_cfg    <= cfg;
      i_new_config_val <= 1'b1;
      @(posedge clk);
      i_new_config_val <= 1'b0;
   endtask

   task automatic start_display(input logic dyn);
      @(posedge clk);
      i_static_dyn  <= dyn;
      i_new_display <= 1'b1;
      @(posedge clk);
      i_new_display <= 1'b0;
   endtask

   // Busy falls at the last transfer while one frame is still on the pins
   task automatic wait_static_run();
      while (!o_static_busy) @(posedge clk);
      while (o_static_busy) @(posedge clk);
      repeat (DRAIN_CYCLES) @(posedge clk);
   endtask

   task automatic wait_scroll_run();
      while (!o_scroller_busy) @(posedge clk);
      while (o_scroller_busy) @(posedge clk);
      repeat (DRAIN_CYCLES) @(posedge clk);
   endtask

   task automatic split_frames();
      cfg_seen.delete();
      scroll_seen.delete();
      foreach (frames[i]) begin
         if (frames[i][15:8] >= REG_DIGIT0 && frames[i][15:8] < REG_DIGIT0 + NB_DIGITS) begin
            scroll_seen.push_back(frames[i]);
         end else begin
            cfg_seen.push_back(frames[i]);
         end
      end
   endtask

   task automatic check_config_frames(input display_cfg_t cfg);
      int i;
      check_value(cfg_seen.size(), 5, "config frame count");
      for (i = 0; i < cfg_seen.size() && i < 5; i++) begin
         check_value(cfg_seen[i], config_frame(cfg, i), "config frame");
      end
   endtask

   task automatic check_static_frames(input logic [7:0] start, input int len);
      logic [7:0] addr;
      int         i;
      for (i = 0; i < frames.size(); i++) begin
         addr = start + 8'(i % len);
         check_value(frames[i], static_mem[addr], "static frame");
      end
   endtask

   // Digit d of window k shows byte (k + d - 1) mod len of the message
   task automatic check_scroll_frames(input logic [7:0] start, input int len);
      logic [7:0]  addr;
      logic [15:0] exp;
      int          i;
      int          k;
      int          d;
      check_value(scroll_seen.size(), 8 * len, "scroll frame count");
      for (i = 0; i < scroll_seen.size() && i < 8 * len; i++) begin
         k    = i / 8;
         d    = i % 8 + 1;
         addr = start + 8'((k + d - 1) % len);
         exp  = {8'(d), scroll_mem[addr]};
         check_value(scroll_seen[i], exp, "scroll frame");
      end
   endtask

   // ==========================================================
   // Directed tests
   // ==========================================================
   task automatic test_config();
      display_cfg_t cfg;
      int           errs;
      int           done_before;
      errs = err_cnt;
      frames.delete();
      cfg = {random_word(), 1'b1};
      done_before = done_cnt;
      send_config(cfg);
      while (done_cnt == done_before) @(posedge clk);
      repeat (DRAIN_CYCLES) @(posedge clk);
      check_value(done_cnt, done_before + 1, "config done pulses");
      cfg_seen = frames;
      check_config_frames(cfg);
      report_test("config", errs);
   endtask

   task automatic test_static_single();
      int errs;
      errs = err_cnt;
      frames.delete();
      write_static_ram(8'd20, 8);
      @(posedge clk);
      i_static_cfg <= {8'd20, 8'd27, 1'b0};
      start_display(1'b0);
      wait_static_run();
      check_value(frames.size(), 8, "static frame count");
      check_static_frames(8'd20, 8);
      report_test("static_single", errs);
   endtask

   task automatic test_static_loop();
      int errs;
      errs = err_cnt;
      frames.delete();
      write_static_ram(8'd40, 3);
      @(posedge clk);
      i_static_cfg <= {8'd40, 8'd42, 1'b1};
      start_display(1'b0);
      // Two full passes before loop is cleared, so the third pass ends the run
      while (frames.size() < 7) @(posedge clk);
      i_static_cfg.loop <= 1'b0;
      wait_static_run();
      check_value(frames.size(), 9, "loop frame count after loop cleared");
      check_static_frames(8'd40, 3);
      report_test("static_loop", errs);
   endtask

   task automatic test_scroll();
      int errs;
      errs = err_cnt;
      frames.delete();
      // Message wraps through RAM address 0
      write_scroll_ram(8'd252, MSG_LEN);
      @(posedge clk);
      i_scroll_cfg <= {8'd252, 8'(MSG_LEN), 32'(TEMPO)};
      start_display(1'b1);
      wait_scroll_run();
      scroll_seen = frames;
      check_scroll_frames(8'd252, MSG_LEN);
      report_test("scroll", errs);
   endtask

   task automatic test_priority();
      display_cfg_t cfg;
      int           errs;
      int           done_before;
      errs = err_cnt;
      frames.delete();
      write_scroll_ram(8'd100, MSG_LEN);
      @(posedge clk);
      i_scroll_cfg <= {8'd100, 8'(MSG_LEN), 32'(TEMPO)};
      start_display(1'b1);
      while (frames.size() < 3) @(posedge clk);
      cfg = {random_word(), 1'b0};
      done_before = done_cnt;
      send_config(cfg);
      wait_scroll_run();
      check_value(done_cnt, done_before + 1, "config done pulses during scroll");
      split_frames();
      check_config_frames(cfg);
      check_scroll_frames(8'd100, MSG_LEN);
      report_test("priority", errs);
   endtask

   task automatic test_ignored_start();
      int errs;
      errs = err_cnt;
      frames.delete();
      @(posedge clk);
      i_static_cfg <= {8'd20, 8'd27, 1'b0};
      start_display(1'b0);
      while (!o_static_busy) @(posedge clk);
      start_display(1'b1);
      start_display(1'b0);
      check_value(o_scroller_busy, 1'b0, "scroller started while static busy");
      wait_static_run();
      check_value(frames.size(), 8, "frame count with extra starts");
      check_static_frames(8'd20, 8);
      report_test("ignored_start", errs);
   endtask

   initial begin
      i_rst_n          = 1'b0;
      i_static_dyn     = 1'b0;
      i_new_display    = 1'b0;
      i_new_config_val = 1'b0;
      i_display_cfg    = '0;
      i_static_cfg     = '0;
      i_scroll_cfg     = '0;
      i_static_wr      = '0;
      i_scroll_wr      = '0;
      repeat (4) @(posedge clk);
      i_rst_n <= 1'b1;
      check_value({o_max7219_clk, o_max7219_load, o_max7219_data, o_config_done,
                   o_static_busy, o_scroller_busy}, 0, "outputs after reset");
      repeat (2) @(posedge clk);
      test_config();
      test_static_single();
      test_static_loop();
      test_scroll();
      test_priority();
      test_ignored_start();
      $display("Tests run: %0d, checks failed: %0d", test_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
